// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// instruction queue sizing
`define IQ_DEPTH 16   // entries in the queue
`define IQ_CNT_W 5    // count holds 0..16

// instruction memory sizing
`define IMEM_WORDS 256 // 1 KiB of code
`define IMEM_IDX_W 8   // word index, pc bits 9:2

// program counter
`define RESET_PC 32'h0000_0000 // first fetch after reset
`define PC_STEP  4             // one 32-bit word per fetch

`endif

// ==== design/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    // byte address as seen by fetch and memory
    typedef logic [31:0] pc_t;

    // raw rv32i instruction word
    typedef logic [31:0] instr_t;

    // word index into the instruction memory
    typedef logic [`IMEM_IDX_W-1:0] imem_idx_t;

    // queue occupancy, one bit wider than the pointers
    typedef logic [`IQ_CNT_W-1:0] iq_cnt_t;

endpackage

// ==== design/pc_gen.sv ====
`include "fetch_macros.svh"

module pc_gen (
    input  logic             clk,
    input  logic             reset,
    input  logic             advance,  // request accepted this cycle
    input  logic             jump_en,
    input  fetch_pkg::pc_t   jump_pc,
    input  logic             flush,
    input  fetch_pkg::pc_t   flush_pc,
    output fetch_pkg::pc_t   pc
);

    fetch_pkg::pc_t flush_tgt;
    fetch_pkg::pc_t jump_tgt;
    fetch_pkg::pc_t next_seq;

    // targets are word aligned, low bits dropped
    assign flush_tgt = {flush_pc[31:2], 2'b00};
    assign jump_tgt  = {jump_pc[31:2], 2'b00};

    assign next_seq = pc + fetch_pkg::pc_t'(`PC_STEP); // sequential next word

    // flush beats jump, any redirect beats advance
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (flush) begin
            pc <= flush_tgt;
        end else if (jump_en) begin
            pc <= jump_tgt;
        end else if (advance) begin
            pc <= next_seq;
        end
        // otherwise hold, stall or back-pressure
    end

endmodule

// ==== design/instr_queue.sv ====
`include "fetch_macros.svh"

module instr_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,       // redirect, drop everything
    input  logic                 wr_en,
    input  fetch_pkg::pc_t       wr_pc,
    input  fetch_pkg::instr_t    wr_instr,
    input  logic                 rd_en,
    output logic                 head_valid,
    output fetch_pkg::pc_t       head_pc,
    output fetch_pkg::instr_t    head_instr,
    output fetch_pkg::iq_cnt_t   count
);

    // pointers are one bit narrower than count and wrap at depth
    logic [`IQ_CNT_W-2:0] wr_ptr;
    logic [`IQ_CNT_W-2:0] rd_ptr;

    // pc and word kept side by side
    fetch_pkg::pc_t    pc_mem    [`IQ_DEPTH];
    fetch_pkg::instr_t instr_mem [`IQ_DEPTH];

    logic full;
    logic do_wr;
    logic do_rd;

    assign full       = (count == fetch_pkg::iq_cnt_t'(`IQ_DEPTH));
    assign head_valid = (count != '0); // anything waiting

    // a full queue blocks the write even if a read happens too
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && head_valid; // never pop an empty queue

    // storage array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_mem[wr_ptr]    <= wr_pc;
            instr_mem[wr_ptr] <= wr_instr;
        end
    end

    // pointers
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps 15 -> 0
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0; // clear wins over a same-cycle write
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none, or both at once
            endcase
        end
    end

    // show-ahead head, read data ready before rd_en
    assign head_pc    = pc_mem[rd_ptr];
    assign head_instr = instr_mem[rd_ptr];

endmodule

// ==== design/imem_ram.sv ====
`include "fetch_macros.svh"

module imem_ram (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read,
    input  fetch_pkg::pc_t        addr,
    output logic                  stall,
    input  logic                  mem_stall,  // external wait from the system
    output logic                  resp,
    output fetch_pkg::instr_t     rdata,
    output fetch_pkg::pc_t        raddr,      // address the data belongs to
    input  logic                  load_we,
    input  fetch_pkg::imem_idx_t  load_idx,
    input  fetch_pkg::instr_t     load_data
);

    fetch_pkg::instr_t    mem [`IMEM_WORDS];
    fetch_pkg::imem_idx_t rd_idx;
    logic                 accept;

    assign stall  = mem_stall; // straight through, no internal wait
    assign accept = read && !mem_stall;
    assign rd_idx = addr[`IMEM_IDX_W+1:2]; // byte address to word index

    // preload port, only driven during reset
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_idx] <= load_data;
        end
    end

    // registered read, data and echoed address
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[rd_idx];
            raddr <= addr;
        end
    end

    // response pulse, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            resp <= 1'b0;
        end else begin
            resp <= accept;
        end
    end

endmodule

// ==== design/fetch.sv ====
`include "fetch_macros.svh"

module fetch (
    input  logic                clk,
    input  logic                reset,
    // redirects
    input  logic                jump_en,
    input  fetch_pkg::pc_t      jump_pc,
    input  logic                flush,
    input  fetch_pkg::pc_t      flush_pc,
    // memory request
    output logic                imem_read,
    output fetch_pkg::pc_t      imem_addr,
    input  logic                imem_stall,
    // memory response
    input  logic                imem_resp,
    input  fetch_pkg::instr_t   imem_rdata,
    input  fetch_pkg::pc_t      imem_raddr,
    // decode side
    output logic                instr_valid,
    output fetch_pkg::instr_t   instr,
    output fetch_pkg::pc_t      instr_pc,
    input  logic                instr_ready
);

    fetch_pkg::pc_t     pc;
    fetch_pkg::iq_cnt_t iq_count;
    fetch_pkg::iq_cnt_t occupancy;  // queued plus the read on its way
    logic               head_valid;
    logic               redirect;
    logic               req_accept;
    logic               in_flight;  // response due this cycle
    logic               drop;       // response due this cycle is stale
    logic               iq_wr;
    logic               iq_rd;

    assign redirect = flush || jump_en;

    // reserve a slot for the outstanding read so nothing is lost
    assign occupancy  = iq_count + fetch_pkg::iq_cnt_t'(in_flight);
    assign imem_read  = (occupancy < fetch_pkg::iq_cnt_t'(`IQ_DEPTH));
    assign imem_addr  = pc;
    assign req_accept = imem_read && !imem_stall;

    // one-cycle memory, so in-flight is just last cycle's accept
    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
            drop      <= 1'b0;
        end else begin
            in_flight <= req_accept;
            drop      <= redirect && req_accept; // read issued on the old path
        end
    end

    // stale responses never reach the queue
    assign iq_wr = imem_resp && !drop;

    // nothing leaves the queue in a redirect cycle
    assign instr_valid = head_valid && !redirect;
    assign iq_rd       = instr_valid && instr_ready;

    pc_gen u_pc_gen (
        .clk      (clk),
        .reset    (reset),
        .advance  (req_accept),
        .jump_en  (jump_en),
        .jump_pc  (jump_pc),
        .flush    (flush),
        .flush_pc (flush_pc),
        .pc       (pc)
    );

    instr_queue u_iq (
        .clk        (clk),
        .reset      (reset),
        .clear      (redirect), // old path thrown away
        .wr_en      (iq_wr),
        .wr_pc      (imem_raddr),
        .wr_instr   (imem_rdata),
        .rd_en      (iq_rd),
        .head_valid (head_valid),
        .head_pc    (instr_pc),
        .head_instr (instr),
        .count      (iq_count)
    );

endmodule

// ==== design/fetch_sys.sv ====
module fetch_sys (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  jump_en,
    input  fetch_pkg::pc_t        jump_pc,
    input  logic                  flush,
    input  fetch_pkg::pc_t        flush_pc,
    input  logic                  mem_stall,
    // preload, testbench only
    input  logic                  load_we,
    input  fetch_pkg::imem_idx_t  load_idx,
    input  fetch_pkg::instr_t     load_data,
    // toward decode
    output logic                  instr_valid,
    output fetch_pkg::instr_t     instr,
    output fetch_pkg::pc_t        instr_pc,
    input  logic                  instr_ready
);

    // fetch <-> memory
    logic              imem_read;
    fetch_pkg::pc_t    imem_addr;
    logic              imem_stall;
    logic              imem_resp;
    fetch_pkg::instr_t imem_rdata;
    fetch_pkg::pc_t    imem_raddr;

    fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_pc     (jump_pc),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .imem_read   (imem_read),
        .imem_addr   (imem_addr),
        .imem_stall  (imem_stall),
        .imem_resp   (imem_resp),
        .imem_rdata  (imem_rdata),
        .imem_raddr  (imem_raddr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_ready (instr_ready)
    );

    imem_ram u_imem (
        .clk       (clk),
        .reset     (reset),
        .read      (imem_read),
        .addr      (imem_addr),
        .stall     (imem_stall),
        .mem_stall (mem_stall),
        .resp      (imem_resp),
        .rdata     (imem_rdata),
        .raddr     (imem_raddr),
        .load_we   (load_we),
        .load_idx  (load_idx),
        .load_data (load_data)
    );

endmodule

// ==== tests/fetch_sys_chk.sv ====
`include "fetch_macros.svh"

module fetch_sys_chk (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                jump_en,
    input  logic                instr_valid,
    input  logic                imem_read,
    input  fetch_pkg::iq_cnt_t  iq_count
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0; // read by the testbench at the end

    // queue can never hold more than its depth
    count_in_range: assert property (@(posedge clk) disable iff (reset)
        iq_count <= fetch_pkg::iq_cnt_t'(`IQ_DEPTH))
    else begin
        fail_count++;
        $error("queue count %0d above depth", iq_count);
    end

    // decode sees nothing while the path changes
    no_valid_on_redirect: assert property (@(posedge clk) disable iff (reset)
        (flush || jump_en) |-> !instr_valid)
    else begin
        fail_count++;
        $error("instr_valid high in a redirect cycle");
    end

    // full queue, so no new read may go out
    no_read_when_full: assert property (@(posedge clk) disable iff (reset)
        (iq_count == fetch_pkg::iq_cnt_t'(`IQ_DEPTH)) |-> !imem_read)
    else begin
        fail_count++;
        $error("imem_read high with a full queue");
    end

endmodule

bind fetch fetch_sys_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .jump_en     (jump_en),
    .instr_valid (instr_valid),
    .imem_read   (imem_read),
    .iq_count    (iq_count)
);

// ==== tests/fetch_sys_tb.sv ====
`include "fetch_macros.svh"

module fetch_sys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned STIM_CYCLES  = 3000;
    // preload + reset + random phase, a third more for the tail
    localparam int unsigned TIMEOUT_CYCLES =
        `IMEM_WORDS + RESET_CYCLES + STIM_CYCLES + STIM_CYCLES / 3;

    logic                 clk;
    logic                 reset;
    logic                 jump_en;
    fetch_pkg::pc_t       jump_pc;
    logic                 flush;
    fetch_pkg::pc_t       flush_pc;
    logic                 mem_stall;
    logic                 load_we;
    fetch_pkg::imem_idx_t load_idx;
    fetch_pkg::instr_t    load_data;
    logic                 instr_valid;
    fetch_pkg::instr_t    instr;
    fetch_pkg::pc_t       instr_pc;
    logic                 instr_ready;

    fetch_pkg::instr_t    model_mem [`IMEM_WORDS]; // copy of the preload
    fetch_pkg::pc_t       exp_pc;                  // next pc decode should see
    fetch_pkg::imem_idx_t model_idx;
    logic                 after_ff;                // last dequeue was index 255
    logic [31:0]          rng_state;
    int unsigned          pc_errors = 0;
    int unsigned          instr_errors = 0;
    int unsigned          valid_errors = 0;
    int unsigned          other_errors = 0;
    int unsigned          chk_errors;
    int unsigned          deq_count = 0;
    int unsigned          wraps = 0;
    int unsigned          wrap_start;
    int unsigned          jump_count = 0;
    int unsigned          flush_count = 0;
    int unsigned          both_count = 0;
    int unsigned          cycle_cnt = 0;

    fetch_sys u_dut (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_pc     (jump_pc),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .mem_stall   (mem_stall),
        .load_we     (load_we),
        .load_idx    (load_idx),
        .load_data   (load_data),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_ready (instr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // true with roughly pct percent probability
    function automatic logic chance(input int unsigned pct);
        return (next_random() % 32'd100) < pct;
    endfunction

    task automatic check_pc(input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp);
        if (got !== exp) begin
            pc_errors++;
            $display("** Error: instr_pc got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_instr(input fetch_pkg::instr_t got, input fetch_pkg::instr_t exp);
        if (got !== exp) begin
            instr_errors++;
            $display("** Error: instr got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            valid_errors++;
            $display("** Error: instr_valid got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    // one random cycle of decode, memory and redirect activity
    task automatic drive_random();
        logic [31:0] pick;
        instr_ready <= chance(60);
        mem_stall   <= chance(20);
        jump_pc     <= next_random();
        flush_pc    <= next_random();
        pick = next_random() % 32'd100;
        jump_en <= (pick < 32'd2) || (pick == 32'd3); // 3% jump, 1% of that with flush
        flush   <= (pick == 32'd2) || (pick == 32'd3);
    endtask

    // reference model, sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        model_idx = exp_pc[`IMEM_IDX_W+1:2]; // word index is pc bits 9:2
        if (reset) begin
            exp_pc   = `RESET_PC;
            after_ff = 1'b0;
        end else begin
            if (instr_valid && instr_ready) begin
                check_pc(instr_pc, exp_pc);
                check_instr(instr, model_mem[model_idx]);
                if (after_ff && model_idx == '0) begin
                    wraps++; // crossed the top of the memory
                end
                after_ff = (model_idx == '1);
                exp_pc   = exp_pc + fetch_pkg::pc_t'(`PC_STEP);
                deq_count++;
            end
            // redirect, flush first, low bits cleared
            if (flush) begin
                exp_pc   = {flush_pc[31:2], 2'b00};
                after_ff = 1'b0;
                flush_count++;
                if (jump_en) begin
                    both_count++;
                end
            end else if (jump_en) begin
                exp_pc   = {jump_pc[31:2], 2'b00};
                after_ff = 1'b0;
                jump_count++;
            end
        end
    end

    // stops a hung run
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        jump_en     = 1'b0;
        jump_pc     = '0;
        flush       = 1'b0;
        flush_pc    = '0;
        mem_stall   = 1'b0;
        load_we     = 1'b0;
        load_idx    = '0;
        load_data   = '0;
        instr_ready = 1'b0;
        rng_state   = 32'hdbf3_6536;

        // preload every word, reset stays up throughout
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(posedge clk);
            model_mem[i] = next_random();
            load_we   <= 1'b1;
            load_idx  <= fetch_pkg::imem_idx_t'(i);
            load_data <= model_mem[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_valid(instr_valid, 1'b0); // queue still empty

        repeat (STIM_CYCLES) begin
            @(posedge clk);
            drive_random();
        end

        // flush alone shows up as more flushes than flush with jump
        if (deq_count == 0 || jump_count == 0 || flush_count == both_count
                || both_count == 0) begin
            other_errors++;
            $display("random phase missed dequeues, jumps, flushes or flush with jump");
        end

        // directed wrap, jump just below the top of memory
        @(posedge clk);
        jump_en     <= 1'b1;
        jump_pc     <= 32'h0000_03f1; // aligns to index 252
        flush       <= 1'b0;
        instr_ready <= 1'b1;
        mem_stall   <= 1'b0;
        @(posedge clk);
        jump_en    <= 1'b0;
        wrap_start = wraps;
        while (wraps == wrap_start) begin
            @(posedge clk);
        end

        @(posedge clk);
        instr_ready <= 1'b0;
        repeat (4) @(posedge clk);

        chk_errors = u_dut.u_fetch.u_chk.fail_count;
        $display("errors: instr_pc %0d, instr %0d, instr_valid %0d, other %0d, assertions %0d",
                 pc_errors, instr_errors, valid_errors, other_errors, chk_errors);
        if (pc_errors + instr_errors + valid_errors + other_errors + chk_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== fetch_sys.f ====
+incdir+include
design/fetch_pkg.sv
design/pc_gen.sv
design/instr_queue.sv
design/imem_ram.sv
design/fetch.sv
design/fetch_sys.sv
tests/fetch_sys_chk.sv
tests/fetch_sys_tb.sv

// ==== Makefile ====
TOP := fetch_sys_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f fetch_sys.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f fetch_sys.f --top-module fetch_sys

clean:
	rm -rf obj_dir
